// ==== project.f ====
+incdir+hw
hw/tmr_pkg.sv
hw/copy_wr_if.sv
hw/frame_parser.sv
hw/copy_store.sv
hw/agreement_check.sv
hw/vote_ctrl.sv
hw/tmr_rx_top.sv
tests/tb_tmr_rx.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then search the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_tmr_rx -o sim_tmr_rx \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tmr_rx > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log

grep -q "Test failures found" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

// ==== tests/tb_tmr_rx.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "tmr_defs.svh"

module tb_tmr_rx import tmr_pkg::*; ();

	typedef byte_t byte_q_t[$];

	localparam int BUF_BYTES = 2 ** `BUF_AW;

	logic clk;
	logic rst_n;
	logic rx_en;
	byte_t rx_data;
	byte_t data_out;
	logic out_valid;
	logic lost;
	logic busy;

	byte_q_t held[3]; // payload of each copy in the open set
	bit have[3];
	byte_q_t got_q; // replayed bytes
	int lost_cnt;
	int err_cnt;
	int test_cnt;
	int bad_tests;

	tmr_rx_top i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.rx_en(rx_en),
		.rx_data(rx_data),
		.data_out(data_out),
		.out_valid(out_valid),
		.lost(lost),
		.busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	// ========================================
	// checks and reporting
	// ========================================
	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %02h, actual %02h", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_len(input string name, input buf_len_t exp, input buf_len_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %0d, actual %0d", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic abort_run(input string reason);
		$display("timeout: %s", reason);
		$display("Test failures found");
		$finish;
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_cnt++;
		if (err_cnt == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, err_cnt - errs_before);
			bad_tests++;
		end
	endtask

	// ========================================
	// reference model
	// ========================================
	function automatic byte_q_t rand_payload(input int n);
		byte_q_t q;
		q = {};
		for (int i = 0; i < n; i++)
			q.push_back(byte_t'($urandom));
		return q;
	endfunction

	function automatic void start_set();
		for (int i = 0; i < 3; i++) begin
			held[i] = {};
			have[i] = 1'b0;
		end
	endfunction

	function automatic bit copies_match(input int a, input int b);
		if (!have[a] || !have[b])
			return 1'b0;
		if (held[a].size() != held[b].size())
			return 1'b0;
		for (int i = 0; i < held[a].size(); i++)
			if (held[a][i] != held[b][i])
				return 1'b0;
		return 1'b1;
	endfunction

	function automatic void predict(output byte_q_t exp_q, output logic exp_lost);
		bit m12;
		bit m13;
		bit m23;
		m12 = copies_match(0, 1);
		m13 = copies_match(0, 2);
		m23 = copies_match(1, 2);
		exp_q = {};
		if (m12 || m13)
			exp_q = held[0]; // lowest copy of the first matching pair
		else if (m23)
			exp_q = held[1];
		exp_lost = !(m12 && m13 && m23);
	endfunction

	// ========================================
	// stimulus and capture
	// ========================================
	task automatic send_frame(input copy_id_t cp, input byte_q_t pay, input bit track);
		byte_t id_byte;
		id_byte = byte_t'($urandom);
		id_byte[1:0] = cp;
		for (int i = 0; i < `ID_POS; i++) begin
			@(posedge clk);
			#2;
			rx_en = 1'b1;
			rx_data = byte_t'($urandom); // header, dropped
		end
		@(posedge clk);
		#2;
		rx_en = 1'b1;
		rx_data = id_byte;
		foreach (pay[i]) begin
			@(posedge clk);
			#2;
			rx_data = pay[i];
		end
		@(posedge clk);
		#2;
		rx_en = 1'b0;
		rx_data = '0;
		@(posedge clk);
		#2;
		if (track && cp != 2'd0) begin
			if (pay.size() > BUF_BYTES)
				pay = pay[0:BUF_BYTES-1];
			held[int'(cp) - 1] = pay;
			have[int'(cp) - 1] = 1'b1;
		end
	endtask

	task automatic collect_output();
		int waited;
		int idle;
		got_q = {};
		lost_cnt = 0;
		waited = 0;
		idle = 0;
		@(negedge clk);
		while (busy !== 1'b1) begin
			waited++;
			if (waited > 200)
				abort_run("busy never rose after the set was sent");
			@(negedge clk);
		end
		waited = 0;
		while (idle < 3) begin // out_valid trails busy by one cycle
			if (out_valid === 1'b1)
				got_q.push_back(data_out);
			if (lost === 1'b1)
				lost_cnt++;
			idle = (busy === 1'b1) ? 0 : idle + 1;
			waited++;
			if (waited > 300)
				abort_run("busy stayed high after the vote");
			@(negedge clk);
		end
	endtask

	task automatic wait_busy();
		int waited;
		waited = 0;
		@(negedge clk);
		while (busy !== 1'b1) begin
			waited++;
			if (waited > 200)
				abort_run("busy never rose before the blocked frame");
			@(negedge clk);
		end
	endtask

	task automatic check_result(input string name);
		byte_q_t exp_q;
		logic exp_lost;
		predict(exp_q, exp_lost);
		check_len({name, " count"}, buf_len_t'(exp_q.size()), buf_len_t'(got_q.size()));
		for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
			check_byte($sformatf("%s byte %0d", name, i), exp_q[i], got_q[i]);
		check_flag({name, " lost"}, exp_lost, lost_cnt != 0);
		if (lost_cnt > 1) begin
			$display("%s: lost pulsed %0d times instead of once", name, lost_cnt);
			err_cnt++;
		end
	endtask

	task automatic run_set(input string name);
		collect_output();
		check_result(name);
	endtask

	// ========================================
	// tests
	// ========================================
	task automatic idle_after_reset();
		int e0;
		e0 = err_cnt;
		@(negedge clk);
		check_flag("reset busy", 1'b0, busy);
		check_flag("reset out_valid", 1'b0, out_valid);
		check_flag("reset lost", 1'b0, lost);
		report_test("reset", e0);
	endtask

	task automatic all_copies_equal();
		int e0;
		byte_q_t p;
		e0 = err_cnt;
		start_set();
		p = rand_payload(20);
		send_frame(2'd1, p, 1'b1);
		send_frame(2'd2, p, 1'b1);
		send_frame(2'd3, p, 1'b1);
		run_set("all_equal");
		report_test("all_equal", e0);
	endtask

	task automatic one_copy_corrupt();
		int e0;
		int pos;
		byte_q_t p;
		byte_q_t bad;
		e0 = err_cnt;
		p = rand_payload(16);
		bad = p;
		pos = $urandom_range(15, 0);
		bad[pos] ^= 8'h5a;
		start_set();
		send_frame(2'd1, bad, 1'b1); // copy 1 broken
		send_frame(2'd2, p, 1'b1);
		send_frame(2'd3, p, 1'b1);
		run_set("corrupt_copy1");
		start_set();
		send_frame(2'd1, p, 1'b1);
		send_frame(2'd2, p, 1'b1);
		send_frame(2'd3, bad, 1'b1);
		run_set("corrupt_copy3");
		report_test("one_corrupt", e0);
	endtask

	task automatic copy_missing();
		int e0;
		byte_q_t p;
		e0 = err_cnt;
		p = rand_payload(12);
		start_set();
		send_frame(2'd1, p, 1'b1);
		send_frame(2'd3, p, 1'b1);
		run_set("missing_copy2");
		start_set();
		send_frame(2'd1, p, 1'b1);
		send_frame(2'd2, p, 1'b1); // closed by the idle gap
		run_set("gap_close");
		report_test("missing", e0);
	endtask

	task automatic no_agreement();
		int e0;
		byte_q_t p;
		e0 = err_cnt;
		start_set();
		send_frame(2'd1, rand_payload(10), 1'b1);
		send_frame(2'd2, rand_payload(10), 1'b1);
		send_frame(2'd3, rand_payload(10), 1'b1);
		run_set("all_differ");
		p = rand_payload(12);
		start_set();
		send_frame(2'd1, p[0:9], 1'b1); // same prefix, lengths differ
		send_frame(2'd2, p[0:10], 1'b1);
		send_frame(2'd3, p, 1'b1);
		run_set("lengths_differ");
		report_test("no_agreement", e0);
	endtask

	task automatic copy_replaced();
		int e0;
		byte_q_t p;
		byte_q_t bad;
		e0 = err_cnt;
		p = rand_payload(14);
		bad = p;
		bad[3] = ~bad[3];
		start_set();
		send_frame(2'd0, rand_payload(14), 1'b1); // copy 0 dropped
		send_frame(2'd1, p, 1'b1);
		send_frame(2'd2, bad, 1'b1);
		send_frame(2'd2, p, 1'b1); // replaces the bad copy 2
		send_frame(2'd3, p, 1'b1);
		run_set("replace_copy2");
		report_test("replace", e0);
	endtask

	task automatic frame_while_busy();
		int e0;
		byte_q_t p;
		byte_q_t q;
		e0 = err_cnt;
		p = rand_payload(8);
		q = rand_payload(12);
		start_set();
		send_frame(2'd1, p, 1'b1);
		send_frame(2'd2, p, 1'b1);
		send_frame(2'd3, p, 1'b1);
		fork
			collect_output();
			begin
				wait_busy();
				send_frame(2'd1, q, 1'b0); // outlasts the busy window
			end
		join
		check_result("busy_set_a");
		start_set();
		send_frame(2'd2, q, 1'b1);
		send_frame(2'd3, q, 1'b1);
		run_set("busy_set_b");
		report_test("busy_drop", e0);
	endtask

	initial begin
		rst_n = 1'b0;
		rx_en = 1'b0;
		rx_data = '0;
		err_cnt = 0;
		test_cnt = 0;
		bad_tests = 0;
		lost_cnt = 0;
		void'($urandom(32'hb950));
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		idle_after_reset();
		all_copies_equal();
		one_copy_corrupt();
		copy_missing();
		no_agreement();
		copy_replaced();
		frame_while_busy();
		$display("tests run: %0d, tests failed: %0d, errors: %0d", test_cnt, bad_tests, err_cnt);
		if (err_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/tmr_rx_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tmr_rx_top import tmr_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic rx_en,
	input byte_t rx_data,
	output byte_t data_out,
	output logic out_valid,
	output logic lost,
	output logic busy
);

	byte_t rd_data1;
	byte_t rd_data2;
	byte_t rd_data3;
	logic replay;
	logic set_clear;
	buf_addr_t replay_addr;
	copy_id_t replay_sel;
	copy_mask_t copy_present;
	pair_mask_t pair_match;
	buf_len_t len1;
	buf_len_t len2;
	buf_len_t len3;

	copy_wr_if wr_bus ();

	frame_parser u_parser (
		.clk(clk),
		.rst_n(rst_n),
		.rx_en(rx_en),
		.rx_data(rx_data),
		.busy(busy),
		.wr(wr_bus)
	);

	copy_store u_store (
		.clk(clk),
		.wr(wr_bus),
		.replay(replay),
		.replay_addr(replay_addr),
		.rd_data1(rd_data1),
		.rd_data2(rd_data2),
		.rd_data3(rd_data3)
	);

	agreement_check u_check (
		.clk(clk),
		.rst_n(rst_n),
		.wr(wr_bus),
		.rd_data1(rd_data1),
		.rd_data2(rd_data2),
		.rd_data3(rd_data3),
		.set_clear(set_clear),
		.copy_present(copy_present),
		.pair_match(pair_match),
		.len1(len1),
		.len2(len2),
		.len3(len3)
	);

	vote_ctrl u_vote (
		.clk(clk),
		.rst_n(rst_n),
		.frame_end(wr_bus.frame_end),
		.end_copy(wr_bus.copy),
		.rx_en(rx_en),
		.copy_present(copy_present),
		.pair_match(pair_match),
		.len1(len1),
		.len2(len2),
		.len3(len3),
		.busy(busy),
		.replay(replay),
		.set_clear(set_clear),
		.replay_addr(replay_addr),
		.replay_sel(replay_sel),
		.out_valid(out_valid),
		.lost(lost)
	);

	// chosen copy onto the output
	always_comb begin
		case (replay_sel)
			2'd1: data_out = rd_data1;
			2'd2: data_out = rd_data2;
			2'd3: data_out = rd_data3;
			default: data_out = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/vote_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "tmr_defs.svh"

module vote_ctrl import tmr_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic frame_end,
	input copy_id_t end_copy,
	input logic rx_en,
	input copy_mask_t copy_present,
	input pair_mask_t pair_match,
	input buf_len_t len1,
	input buf_len_t len2,
	input buf_len_t len3,
	output logic busy,
	output logic replay,
	output logic set_clear,
	output buf_addr_t replay_addr,
	output copy_id_t replay_sel,
	output logic out_valid,
	output logic lost
);

	localparam int GAP_W = $clog2(`SET_GAP + 1);
	localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(`SET_GAP - 1);

	vote_state_t state;
	logic [1:0] dec_cnt;
	logic [GAP_W-1:0] gap_cnt;
	logic close;
	logic last_dec;
	logic last_rep;
	logic go;
	copy_id_t pick;
	buf_len_t pick_len;
	buf_len_t rep_len;

	// idle cycles since rx_en was last high
	always_ff @(posedge clk) begin
		if (!rst_n || rx_en)
			gap_cnt <= '0;
		else if (gap_cnt != GAP_LAST)
			gap_cnt <= gap_cnt + 1'b1;
	end

	assign close = (frame_end && (end_copy == 2'd3))
		|| (!rx_en && (gap_cnt == GAP_LAST) && (|copy_present));

	// ========================================
	// vote
	// ========================================
	always_comb begin
		if (pair_match[0] || pair_match[1])
			pick = 2'd1;
		else if (pair_match[2])
			pick = 2'd2;
		else
			pick = 2'd0; // no pair agrees
		case (pick)
			2'd1: pick_len = len1;
			2'd2: pick_len = len2;
			2'd3: pick_len = len3;
			default: pick_len = '0;
		endcase
	end

	assign go = (pick != 2'd0) && (pick_len != '0);
	assign last_dec = (state == VS_DECIDE) && (dec_cnt == 2'd2);
	assign last_rep = (state == VS_REPLAY) && (buf_len_t'(replay_addr) == rep_len - 1'b1);

	assign busy = (state != VS_COLLECT);
	assign replay = (state == VS_REPLAY);
	assign lost = last_dec && !((copy_present == 3'b111) && (pair_match == 3'b111));
	assign set_clear = last_rep || (last_dec && !go);

	// ========================================
	// state machine
	// ========================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= VS_COLLECT;
			dec_cnt <= 2'd0;
			replay_sel <= 2'd0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= (state == VS_REPLAY); // data comes one cycle after the address
			case (state)
				VS_COLLECT: begin
					dec_cnt <= 2'd0;
					if (close)
						state <= VS_DECIDE;
				end
				VS_DECIDE: begin
					dec_cnt <= dec_cnt + 1'b1; // comparisons settle here
					if (last_dec) begin
						replay_sel <= pick;
						state <= go ? VS_REPLAY : VS_COLLECT;
					end
				end
				VS_REPLAY: begin
					if (last_rep)
						state <= VS_COLLECT;
				end
				default: state <= VS_COLLECT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (last_dec) begin
			rep_len <= pick_len;
			replay_addr <= '0;
		end else if (state == VS_REPLAY) begin
			replay_addr <= replay_addr + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/agreement_check.sv ====
`timescale 1ns/100ps
`default_nettype none

module agreement_check import tmr_pkg::*; (
	input logic clk,
	input logic rst_n,
	copy_wr_if.sink wr,
	input byte_t rd_data1,
	input byte_t rd_data2,
	input byte_t rd_data3,
	input logic set_clear,
	output copy_mask_t copy_present,
	output pair_mask_t pair_match,
	output buf_len_t len1,
	output buf_len_t len2,
	output buf_len_t len3
);

	logic en_d;
	copy_id_t copy_d;
	byte_t data_d; // lines up with the stored bytes read back
	copy_mask_t ne; // held copy differs from incoming byte
	pair_mask_t diff;
	pair_mask_t renew;
	pair_mask_t mism;

	always_ff @(posedge clk) begin
		if (!rst_n)
			en_d <= 1'b0;
		else
			en_d <= wr.wr_en;
	end

	always_ff @(posedge clk) begin
		copy_d <= wr.copy;
		data_d <= wr.data;
	end

	assign ne[0] = copy_present[0] && (rd_data1 != data_d);
	assign ne[1] = copy_present[1] && (rd_data2 != data_d);
	assign ne[2] = copy_present[2] && (rd_data3 != data_d);

	// ========================================
	// pair mismatch flags
	// ========================================
	always_comb begin
		diff = '0;
		renew = '0;
		if (en_d) begin
			case (copy_d)
				2'd1: diff = {1'b0, ne[2], ne[1]};
				2'd2: diff = {ne[2], 1'b0, ne[0]};
				2'd3: diff = {ne[1], ne[0], 1'b0};
				default: diff = '0;
			endcase
		end
		if (wr.frame_start) begin
			case (wr.copy)
				2'd1: renew = 3'b011; // pairs holding the replaced copy
				2'd2: renew = 3'b101;
				2'd3: renew = 3'b110;
				default: renew = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n || set_clear) begin
			mism <= '0;
			copy_present <= '0;
		end else begin
			mism <= (mism & ~renew) | diff;
			if (wr.frame_end)
				copy_present[wr.copy - 2'd1] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr.frame_end) begin
			case (wr.copy)
				2'd1: len1 <= wr.len;
				2'd2: len2 <= wr.len;
				2'd3: len3 <= wr.len;
				default: ;
			endcase
		end
	end

	assign pair_match[0] = !mism[0] && copy_present[0] && copy_present[1] && (len1 == len2);
	assign pair_match[1] = !mism[1] && copy_present[0] && copy_present[2] && (len1 == len3);
	assign pair_match[2] = !mism[2] && copy_present[1] && copy_present[2] && (len2 == len3);

endmodule

`default_nettype wire

// ==== hw/copy_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module copy_store import tmr_pkg::*; (
	input logic clk,
	copy_wr_if.sink wr,
	input logic replay,
	input buf_addr_t replay_addr,
	output byte_t rd_data1,
	output byte_t rd_data2,
	output byte_t rd_data3
);

	localparam int DEPTH = 2 ** $bits(buf_addr_t);

	buf_addr_t rd_addr;

	// all three follow the incoming address while collecting
	assign rd_addr = replay ? replay_addr : wr.addr;

	for (genvar i = 0; i < 3; i++) begin : g_buf
		byte_t mem [DEPTH];
		byte_t rd_q;

		always_ff @(posedge clk) begin
			if (wr.wr_en && (wr.copy == copy_id_t'(i + 1)))
				mem[wr.addr] <= wr.data;
			rd_q <= mem[rd_addr]; // one cycle read latency
		end
	end

	assign rd_data1 = g_buf[0].rd_q;
	assign rd_data2 = g_buf[1].rd_q;
	assign rd_data3 = g_buf[2].rd_q;

endmodule

`default_nettype wire

// ==== hw/frame_parser.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "tmr_defs.svh"

module frame_parser import tmr_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic rx_en,
	input byte_t rx_data,
	input logic busy,
	copy_wr_if.parser wr
);

	localparam int OFF_MAX = `ID_POS + 1; // offset counter stops past the id byte
	localparam int OFF_W = $clog2(OFF_MAX + 1);

	logic rx_en_q;
	byte_t rx_data_q;
	logic [OFF_W-1:0] off;
	logic blk; // frame began while busy
	logic blk_now;
	logic accept; // valid copy number seen in this frame
	logic id_ok;
	logic wr_go;
	copy_id_t cur_copy;
	buf_len_t pay_cnt;

	// ========================================
	// input register stage
	// ========================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_en_q <= 1'b0;
		end else begin
			rx_en_q <= rx_en;
		end
	end

	always_ff @(posedge clk) begin
		rx_data_q <= rx_data;
	end

	// ========================================
	// offset and copy number
	// ========================================
	assign blk_now = (off == '0) ? busy : blk; // first byte sees busy directly
	assign id_ok = rx_en_q && (off == OFF_W'(`ID_POS)) && !blk_now
		&& (rx_data_q[1:0] != 2'd0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			off <= '0;
			blk <= 1'b0;
			accept <= 1'b0;
		end else if (!rx_en_q) begin
			off <= '0; // gap between frames
			accept <= 1'b0;
		end else begin
			if (off != OFF_W'(OFF_MAX))
				off <= off + 1'b1;
			if (off == '0)
				blk <= busy;
			if (id_ok)
				accept <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (id_ok) begin
			cur_copy <= copy_id_t'(rx_data_q[1:0]);
			pay_cnt <= '0;
		end else if (wr_go) begin
			pay_cnt <= pay_cnt + 1'b1;
		end
	end

	// bytes past the buffer are dropped
	assign wr_go = rx_en_q && accept && !pay_cnt[`BUF_AW];

	assign wr.wr_en = wr_go;
	assign wr.copy = id_ok ? copy_id_t'(rx_data_q[1:0]) : cur_copy; // new number at frame_start
	assign wr.addr = pay_cnt[`BUF_AW-1:0];
	assign wr.data = rx_data_q;
	assign wr.frame_start = id_ok;
	assign wr.frame_end = accept && !rx_en_q;
	assign wr.len = pay_cnt;

endmodule

`default_nettype wire

// ==== hw/copy_wr_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface copy_wr_if import tmr_pkg::*; ();

	logic wr_en; // payload byte strobe
	copy_id_t copy; // copy number of the current frame
	buf_addr_t addr;
	byte_t data;
	logic frame_start; // copy byte accepted
	logic frame_end; // cycle after rx_en falls
	buf_len_t len; // valid with frame_end

	modport parser (
		output wr_en, copy, addr, data,
		output frame_start, frame_end, len
	);

	modport sink (
		input wr_en, copy, addr, data,
		input frame_start, frame_end, len
	);

endinterface

`default_nettype wire

// ==== hw/tmr_pkg.sv ====
`default_nettype none
`include "tmr_defs.svh"

package tmr_pkg;

	typedef logic [7:0] byte_t; // stream and payload byte
	typedef logic [1:0] copy_id_t; // 0 means no copy
	typedef logic [`BUF_AW-1:0] buf_addr_t;
	typedef logic [`BUF_AW:0] buf_len_t; // one extra bit for a full buffer

	// bit 0 is copy 1
	typedef logic [2:0] copy_mask_t;

	// bit 0 pair 1-2, bit 1 pair 1-3, bit 2 pair 2-3
	typedef logic [2:0] pair_mask_t;

	typedef enum logic [1:0] {
		VS_COLLECT,
		VS_DECIDE,
		VS_REPLAY
	} vote_state_t;

endpackage

`default_nettype wire

// ==== hw/tmr_defs.svh ====
`ifndef TMR_DEFS_SVH
`define TMR_DEFS_SVH

// frame layout
`define ID_POS 2 // offset of the copy number byte

// payload buffers
`define BUF_AW 6 // 64 payload bytes per copy

// set closing
`define SET_GAP 8 // idle cycles before an open set is voted

`endif
